/* mfrsd.f */
common/msx_bus_pkg.sv
common/mfrsd_pkg.sv
rom_mapper/mfrsd_ctrl_regs.sv
rom_mapper/mfrsd_bank_regs.sv
rom_mapper/mfrsd_rom_addr.sv
hdl/mfrsd_subslot_mux.sv
hdl/mfrsd_top.sv
tb/tb_mfrsd.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the mfrsd testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_mfrsd -f mfrsd.f -o sim_mfrsd \
    && ./obj_dir/sim_mfrsd | tee sim.log

grep -qs "^All tests passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb/tb_mfrsd.sv */
`timescale 1ns/1ps

module tb_mfrsd
    import msx_bus_pkg::*, mfrsd_pkg::*;
();

    localparam int ram_addr_w = 27;

    logic                  cpu_bus;
    logic                  arst_n;
    logic                  mreq;
    logic                  req;
    logic                  rd;
    logic                  wr;
    logic [cpu_addr_w-1:0] addr;
    logic [cpu_data_w-1:0] data;
    subslot_e              subslot;
    logic [7:0]            mapper_page;
    logic                  ram_cs;
    logic                  ram_rnw;
    logic [ram_addr_w-1:0] ram_addr;
    logic                  slot_expander_force_en;

    // Reference state of the ROM mapper
    mfrsd_config_u       m_cfg;
    mapper_ctrl_u        m_ctrl;
    logic [offset_w-1:0] m_offset;
    logic [7:0]          m_banks [4];
    logic [31:0]         lcg_state = 32'h27c8;

    mfrsd_top #(
        .ram_addr_w (ram_addr_w)
    ) u_mfrsd_top (
        .cpu_bus                (cpu_bus),
        .arst_n                 (arst_n),
        .mreq                   (mreq),
        .req                    (req),
        .rd                     (rd),
        .wr                     (wr),
        .addr                   (addr),
        .data                   (data),
        .subslot                (subslot),
        .mapper_page            (mapper_page),
        .ram_cs                 (ram_cs),
        .ram_rnw                (ram_rnw),
        .ram_addr               (ram_addr),
        .slot_expander_force_en (slot_expander_force_en)
    );

    always #50 cpu_bus = ~cpu_bus;   // 100 ns bus clock

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic check_ram_addr(input logic [ram_addr_w-1:0] got,
                                  input logic [ram_addr_w-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: ram_addr is %h, expected %h", $time, got, exp);
            $display("Some tests failed");
            $fatal(1, "Mismatch on ram_addr");
        end
    endtask

    // Register and bank updates of one ROM write from the old state
    task automatic model_write(input logic [15:0] a, input logic [7:0] d);
        logic [2:0] p8;
        p8 = a[15:13] - 3'd2;
        if (!m_ctrl.f.bank_lock && p8 < 3'd4) begin
            case (m_ctrl.f.mode)
                mode_konami_scc: begin
                    if (a[12:11] == 2'b10) begin
                        m_banks[p8[1:0]] = m_ctrl.f.bank_mask ? (d & 8'h3F) : d;
                    end
                end
                mode_konami: begin
                    if (((a >= 16'h5000 && a < 16'h5800) || a >= 16'h6000)
                            && !(m_ctrl.f.konami_low_lock && a < 16'h6000)) begin
                        m_banks[p8[1:0]] = m_ctrl.f.bank_mask ? (d & 8'h1F) : d;
                    end
                end
                mode_64k_a, mode_64k_b: begin
                    m_banks[p8[1:0]] = d;
                end
                mode_ascii8_a, mode_ascii8_b: begin
                    if (a >= 16'h6000 && a < 16'h8000) begin
                        m_banks[a[12:11]] = d;
                    end
                end
                default: begin
                    if (a >= 16'h6000 && a < 16'h6800) begin   // ASCII16 low half
                        m_banks[0] = {d[6:0], 1'b0};
                        m_banks[1] = {d[6:0], 1'b1};
                    end
                    if (a >= 16'h7000 && a < 16'h7800) begin
                        m_banks[2] = {d[6:0], 1'b0};
                        m_banks[3] = {d[6:0], 1'b1};
                    end
                end
            endcase
        end
        if (a == 16'h7FFD && !m_ctrl.f.bank_lock) begin
            m_offset[7:0] = d;
        end
        if (a == 16'h7FFE && !m_ctrl.f.bank_lock) begin
            m_offset[9:8] = d[1:0];
        end
        if (a == 16'h7FFC && !m_cfg.f.config_lock) begin
            m_cfg.raw = d;
        end
        if (a == 16'h7FFF && !m_ctrl.f.ctrl_lock) begin
            m_ctrl.raw = d;
        end
    endtask

    function automatic logic is_64k_mode();
        return (m_ctrl.f.mode == mode_64k_a) || (m_ctrl.f.mode == mode_64k_b);
    endfunction

    function automatic logic [ram_addr_w-1:0] exp_rom_addr(input logic [15:0] a);
        logic [2:0]  page;
        logic [15:0] bnum;
        logic [31:0] full;
        page = is_64k_mode() ? {1'b0, a[15:14]} : a[15:13] - 3'd2;
        if (m_cfg.f.dsk_mode && page == 3'd0 && m_banks[0] == 8'd0) begin
            bnum = 16'h03FA;
        end else if (m_cfg.f.dsk_mode && page == 3'd1 && m_banks[1] == 8'd1) begin
            bnum = 16'h03FB;
        end else begin
            bnum = 16'(m_banks[page[1:0]]) + 16'(m_offset);
        end
        full = is_64k_mode() ? {2'b00, bnum, a[13:0]} : {3'b000, bnum, a[12:0]};
        return full[ram_addr_w-1:0];
    endfunction

    function automatic logic [15:0] bank_write_addr(input rom_mode_e mode, input int i,
                                                    input logic [15:0] r);
        case (mode)
            mode_konami:   return (i == 0) ? {5'b01010, r[10:0]} : {3'(i + 2), r[12:0]};
            mode_ascii8_a: return {3'b011, 2'(i), r[10:0]};
            mode_ascii16_a: return (i < 2) ? {5'b01100, r[10:0]} : {5'b01110, r[10:0]};
            default:       return {3'(i + 2), r[12:0]};   // 64 kB takes any page address
        endcase
    endfunction

    function automatic logic [15:0] page_read_addr(input int i, input logic [15:0] r);
        return is_64k_mode() ? {2'(i), r[13:0]} : {3'(i + 2), r[12:0]};
    endfunction

    task automatic drive_idle();
        mreq        = 1'b0;
        req         = 1'b0;
        rd          = 1'b0;
        wr          = 1'b0;
        addr        = '0;
        data        = '0;
        subslot     = subslot_0;
        mapper_page = '0;
    endtask

    task automatic apply_reset();
        int waited;
        @(posedge cpu_bus);
        #10;
        drive_idle();
        arst_n    = 1'b0;
        m_cfg.raw  = 8'h02;   // Mapper and expander on
        m_ctrl.raw = 8'h00;
        m_offset   = '0;
        m_banks    = '{8'd0, 8'd1, 8'd2, 8'd3};
        repeat (8) @(posedge cpu_bus);
        #10;
        arst_n = 1'b1;
        waited = 0;
        while (!(ram_cs === 1'b0 && ram_rnw === 1'b1 && ram_addr === '1) && waited < 20) begin
            @(posedge cpu_bus);
            waited++;
        end
        if (!(ram_cs === 1'b0 && ram_rnw === 1'b1 && ram_addr === '1)) begin
            $display("Timeout: RAM outputs never went idle after reset");
            $display("Some tests failed");
            $fatal(1, "Reset wait timed out");
        end
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge cpu_bus);
        #10;
        mreq    = 1'b1;
        wr      = 1'b1;
        req     = 1'b1;
        subslot = subslot_1;
        addr    = a;
        data    = d;
        @(posedge cpu_bus);
        model_write(a, d);                 // Lands on this edge
        #10;
        drive_idle();
    endtask

    task automatic access_check(input subslot_e s, input logic [15:0] a, input logic [7:0] pg,
                                input logic is_wr, input logic exp_cs,
                                input logic [ram_addr_w-1:0] exp_addr);
        @(posedge cpu_bus);
        #10;
        mreq        = 1'b1;
        rd          = !is_wr;
        wr          = is_wr;
        req         = is_wr;
        subslot     = s;
        addr        = a;
        mapper_page = pg;
        #40;                               // Mid cycle where outputs have settled
        check_bit("ram_cs", ram_cs, exp_cs);
        check_bit("ram_rnw", ram_rnw, !is_wr);
        check_bit("force_en", slot_expander_force_en, !m_cfg.f.expander_disable);
        check_ram_addr(ram_addr, exp_addr);
        @(posedge cpu_bus);
        #10;
        drive_idle();
    endtask

    task automatic rom_read(input logic [15:0] a);
        access_check(subslot_1, a, 8'h00, 1'b0, 1'b1, exp_rom_addr(a));
    endtask

    task automatic read_all_pages();
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            r = lcg_next();
            rom_read(page_read_addr(i, r[15:0]));
        end
    endtask

    task automatic after_reset_test();
        logic [31:0] r;
        apply_reset();
        @(posedge cpu_bus);
        #50;                                   // First clock out of reset
        check_bit("ram_cs", ram_cs, 1'b0);
        check_bit("ram_rnw", ram_rnw, 1'b1);
        check_bit("force_en", slot_expander_force_en, 1'b0);
        check_ram_addr(ram_addr, '1);
        r = lcg_next();
        access_check(subslot_0, r[15:0], 8'h00, 1'b0, 1'b1, ram_addr_w'(r[13:0]));
        r = lcg_next();
        rom_read({3'b010, r[12:0]});
    endtask

    task automatic config_write_test();
        logic [31:0] r;
        apply_reset();
        bus_write(reg_config_addr, 8'h06);     // Expander off
        r = lcg_next();
        access_check(subslot_0, {2'b00, r[13:0]}, 8'h00, 1'b0, 1'b0, '1);
        r = lcg_next();
        access_check(subslot_2, {2'b01, r[13:0]}, r[23:16], 1'b0, 1'b1,
                     exp_rom_addr({2'b01, r[13:0]}));
        bus_write(reg_config_addr, 8'h86);     // Set config_lock
        bus_write(reg_config_addr, 8'h02);     // Must be ignored
        r = lcg_next();
        access_check(subslot_0, {2'b00, r[13:0]}, 8'h00, 1'b0, 1'b0, '1);
    endtask

    task automatic mapper_ram_test();
        logic [31:0] r;
        apply_reset();
        r = lcg_next();
        access_check(subslot_2, r[15:0], r[23:16], 1'b0, 1'b1,
                     ram_addr_w'({r[23:16], r[13:0]}));
        r = lcg_next();
        access_check(subslot_2, r[15:0], r[23:16], 1'b1, 1'b1,
                     ram_addr_w'({r[23:16], r[13:0]}));
    endtask

    task automatic bank_scheme_test();
        logic [31:0] r;
        rom_mode_e   modes [4];
        modes = '{mode_konami, mode_64k_a, mode_ascii8_a, mode_ascii16_a};
        for (int m = 0; m < 4; m++) begin
            for (int pass_no = 0; pass_no < 2; pass_no++) begin
                apply_reset();
                if (pass_no == 1) begin
                    r = lcg_next();
                    bus_write(reg_offset_lo_addr, r[7:0]);
                    bus_write(reg_offset_hi_addr, r[15:8]);
                end
                bus_write(reg_mapper_addr, {modes[m], 5'b00000});
                for (int i = 0; i < 4; i++) begin
                    r = lcg_next();
                    bus_write(bank_write_addr(modes[m], i, r[31:16]), r[7:0]);
                end
                read_all_pages();
            end
        end
    endtask

    task automatic lock_mask_dsk_test();
        apply_reset();
        bus_write(reg_mapper_addr, 8'h22);     // Konami with bank_lock
        bus_write(16'h8000, 8'h55);
        bus_write(reg_offset_lo_addr, 8'h10);
        read_all_pages();
        apply_reset();
        bus_write(reg_mapper_addr, 8'h24);     // Konami with ctrl_lock
        bus_write(reg_mapper_addr, 8'h40);
        read_all_pages();
        apply_reset();
        bus_write(reg_mapper_addr, 8'h29);     // Konami with low lock and mask
        bus_write(16'h5000, 8'h33);
        bus_write(16'h8000, 8'hFF);
        bus_write(16'hA000, 8'hE5);
        read_all_pages();
        apply_reset();
        bus_write(reg_config_addr, 8'h12);     // DSK mode
        access_check(subslot_1, 16'h4123, 8'h00, 1'b0, 1'b1, ram_addr_w'({16'h03FA, 13'h0123}));
        access_check(subslot_1, 16'h6456, 8'h00, 1'b0, 1'b1, ram_addr_w'({16'h03FB, 13'h0456}));
        read_all_pages();
    endtask

    initial begin
        cpu_bus = 1'b0;
        arst_n  = 1'b0;
        drive_idle();
        after_reset_test();
        config_write_test();
        mapper_ram_test();
        bank_scheme_test();
        lock_mask_dsk_test();
        $display("All tests passed");
        $finish;
    end

endmodule

/* hdl/mfrsd_top.sv */
`timescale 1ns/1ps

module mfrsd_top
    import msx_bus_pkg::*, mfrsd_pkg::*;
#(
    parameter int ram_addr_w = 27
) (
    input  logic                  cpu_bus,
    input  logic                  arst_n,
    input  logic                  mreq,
    input  logic                  req,
    input  logic                  rd,
    input  logic                  wr,
    input  logic [cpu_addr_w-1:0] addr,
    input  logic [cpu_data_w-1:0] data,
    input  subslot_e              subslot,
    input  logic [7:0]            mapper_page,
    output logic                  ram_cs,
    output logic                  ram_rnw,
    output logic [ram_addr_w-1:0] ram_addr,
    output logic                  slot_expander_force_en
);

    logic                       rom_sel;
    logic                       rom_wr;
    mfrsd_config_u              cfg;
    mapper_ctrl_u               ctrl;
    logic [offset_w-1:0]        offset;
    logic [3:0][cpu_data_w-1:0] banks;
    logic                       rom_ram_cs;
    logic [ram_addr_w-1:0]      rom_ram_addr;

    mfrsd_ctrl_regs u_ctrl_regs (
        .cpu_bus (cpu_bus),
        .arst_n  (arst_n),
        .rom_wr  (rom_wr),
        .addr    (addr),
        .data    (data),
        .cfg     (cfg),
        .ctrl    (ctrl),
        .offset  (offset)
    );

    mfrsd_bank_regs u_bank_regs (
        .cpu_bus (cpu_bus),
        .arst_n  (arst_n),
        .rom_wr  (rom_wr),
        .addr    (addr),
        .data    (data),
        .ctrl    (ctrl),
        .banks   (banks)
    );

    mfrsd_rom_addr #(
        .ram_addr_w (ram_addr_w)
    ) u_rom_addr (
        .rom_sel      (rom_sel),
        .rd           (rd),
        .addr         (addr),
        .cfg          (cfg),
        .ctrl         (ctrl),
        .offset       (offset),
        .banks        (banks),
        .rom_ram_cs   (rom_ram_cs),
        .rom_ram_addr (rom_ram_addr)
    );

    mfrsd_subslot_mux #(
        .ram_addr_w (ram_addr_w)
    ) u_subslot_mux (
        .mreq                   (mreq),
        .req                    (req),
        .rd                     (rd),
        .wr                     (wr),
        .addr                   (addr),
        .subslot                (subslot),
        .mapper_page            (mapper_page),
        .cfg                    (cfg),
        .rom_ram_cs             (rom_ram_cs),
        .rom_ram_addr           (rom_ram_addr),
        .rom_sel                (rom_sel),
        .rom_wr                 (rom_wr),
        .ram_cs                 (ram_cs),
        .ram_rnw                (ram_rnw),
        .ram_addr               (ram_addr),
        .slot_expander_force_en (slot_expander_force_en)
    );

endmodule

/* hdl/mfrsd_subslot_mux.sv */
`timescale 1ns/1ps

module mfrsd_subslot_mux
    import msx_bus_pkg::*, mfrsd_pkg::*;
#(
    parameter int ram_addr_w = 27
) (
    input  logic                  mreq,
    input  logic                  req,
    input  logic                  rd,
    input  logic                  wr,
    input  logic [cpu_addr_w-1:0] addr,
    input  subslot_e              subslot,
    input  logic [7:0]            mapper_page,
    input  mfrsd_config_u         cfg,
    input  logic                  rom_ram_cs,
    input  logic [ram_addr_w-1:0] rom_ram_addr,
    output logic                  rom_sel,
    output logic                  rom_wr,
    output logic                  ram_cs,
    output logic                  ram_rnw,
    output logic [ram_addr_w-1:0] ram_addr,
    output logic                  slot_expander_force_en
);

    logic                  exp_en;
    logic                  cs0;
    logic                  sel2;
    logic                  cs2;
    logic [ram_addr_w-1:0] addr0;
    logic [ram_addr_w-1:0] addr1;
    logic [ram_addr_w-1:0] addr2;

    assign exp_en = !cfg.f.expander_disable;

    // Without the expander subslot 1 answers the whole slot
    assign rom_sel = mreq && ((subslot == subslot_1) || !exp_en);
    assign rom_wr  = rom_sel && wr && req;

    assign cs0  = mreq && exp_en && (subslot == subslot_0) && rd;      // Read only window
    assign sel2 = mreq && exp_en && !cfg.f.mapper_disable && (subslot == subslot_2);
    assign cs2  = sel2 && (rd || wr);

    // Idle sources park at all ones so the AND merge works
    assign addr0 = cs0 ? ram_addr_w'(addr[13:0]) : '1;
    assign addr1 = rom_ram_cs ? rom_ram_addr : '1;
    assign addr2 = cs2 ? ram_addr_w'({mapper_page, addr[13:0]}) : '1;

    assign ram_cs   = cs0 || rom_ram_cs || cs2;
    assign ram_addr = addr0 & addr1 & addr2;
    assign ram_rnw  = !(sel2 && wr);                 // Only mapper RAM is writable

    assign slot_expander_force_en = mreq && exp_en;

endmodule

/* rom_mapper/mfrsd_rom_addr.sv */
`timescale 1ns/1ps

module mfrsd_rom_addr
    import msx_bus_pkg::*, mfrsd_pkg::*;
#(
    parameter int ram_addr_w = 27
) (
    input  logic                       rom_sel,
    input  logic                       rd,
    input  logic [cpu_addr_w-1:0]      addr,
    input  mfrsd_config_u              cfg,
    input  mapper_ctrl_u               ctrl,
    input  logic [offset_w-1:0]        offset,
    input  logic [3:0][cpu_data_w-1:0] banks,
    output logic                       rom_ram_cs,
    output logic [ram_addr_w-1:0]      rom_ram_addr
);

    localparam int full_w = bank_w + 14;

    logic                  is_64k;
    logic [2:0]            page;
    logic                  rom_area;
    logic [cpu_data_w-1:0] page_bank;
    logic [bank_w-1:0]     bank_num;
    logic [full_w-1:0]     full_addr;

    assign is_64k = (ctrl.f.mode == mode_64k_a) || (ctrl.f.mode == mode_64k_b);

    // 16 kB pages in 64 kB modes, 8 kB pages from 4000 otherwise
    assign page      = is_64k ? {1'b0, addr[15:14]} : addr[15:13] - 3'd2;
    assign rom_area  = page < 3'd4;
    assign page_bank = banks[page[1:0]];

    always_comb begin
        if (cfg.f.dsk_mode && page[1:0] == 2'd0 && banks[0] == 8'd0) begin
            bank_num = dsk_bank0;
        end else if (cfg.f.dsk_mode && page[1:0] == 2'd1 && banks[1] == 8'd1) begin
            bank_num = dsk_bank1;
        end else begin
            bank_num = bank_w'(page_bank) + bank_w'(offset);
        end
    end

    assign full_addr = is_64k ? {bank_num, addr[13:0]}
                              : {1'b0, bank_num, addr[12:0]};

    assign rom_ram_cs   = rom_sel && rd && rom_area;
    assign rom_ram_addr = ram_addr_w'(full_addr);   // Fit to RAM width

endmodule

/* rom_mapper/mfrsd_bank_regs.sv */
`timescale 1ns/1ps

module mfrsd_bank_regs
    import msx_bus_pkg::*, mfrsd_pkg::*;
(
    input  logic                        cpu_bus,
    input  logic                        arst_n,
    input  logic                        rom_wr,
    input  logic [cpu_addr_w-1:0]       addr,
    input  logic [cpu_data_w-1:0]       data,
    input  mapper_ctrl_u                ctrl,
    output logic [3:0][cpu_data_w-1:0]  banks
);

    logic [2:0]            page8k;
    logic                  bank_we;
    logic                  konami_hit;
    logic                  konami_blocked;
    logic [cpu_data_w-1:0] scc_data;
    logic [cpu_data_w-1:0] konami_data;
    logic [cpu_data_w-1:0] a16_even;
    logic [cpu_data_w-1:0] a16_odd;

    // 8 kB page inside 4000-BFFF, wraps above 3 elsewhere
    assign page8k  = addr[15:13] - 3'd2;
    assign bank_we = rom_wr && !ctrl.f.bank_lock && (page8k < 3'd4);

    assign konami_hit     = (addr[15:11] == 5'b01010) || (addr[15:13] >= 3'b011); // 5000-57FF, 6000+
    assign konami_blocked = ctrl.f.konami_low_lock && (addr < 16'h6000);

    assign scc_data    = ctrl.f.bank_mask ? (data & 8'h3F) : data;
    assign konami_data = ctrl.f.bank_mask ? (data & 8'h1F) : data;

    // ASCII16 maps one 16 kB bank as two 8 kB halves
    assign a16_even = {data[6:0], 1'b0};
    assign a16_odd  = {data[6:0], 1'b1};

    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            banks <= {8'd3, 8'd2, 8'd1, 8'd0};   // Linear mapping of first 32 kB
        end else if (bank_we) begin
            case (ctrl.f.mode)
                mode_konami_scc: begin
                    if (addr[12:11] == 2'b10) begin
                        banks[page8k[1:0]] <= scc_data;
                    end
                end
                mode_konami: begin
                    if (konami_hit && !konami_blocked) begin
                        banks[page8k[1:0]] <= konami_data;
                    end
                end
                mode_64k_a, mode_64k_b: begin
                    banks[page8k[1:0]] <= data;   // Any write in the page
                end
                mode_ascii8_a, mode_ascii8_b: begin
                    if (addr[15:13] == 3'b011) begin
                        banks[addr[12:11]] <= data;
                    end
                end
                mode_ascii16_a, mode_ascii16_b: begin
                    if (addr[15:11] == 5'b01100) begin        // 6000-67FF
                        banks[0] <= a16_even;
                        banks[1] <= a16_odd;
                    end
                    if (addr[15:11] == 5'b01110) begin        // 7000-77FF
                        banks[2] <= a16_even;
                        banks[3] <= a16_odd;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* rom_mapper/mfrsd_ctrl_regs.sv */
`timescale 1ns/1ps

module mfrsd_ctrl_regs
    import msx_bus_pkg::*, mfrsd_pkg::*;
(
    input  logic                  cpu_bus,
    input  logic                  arst_n,
    input  logic                  rom_wr,
    input  logic [cpu_addr_w-1:0] addr,
    input  logic [cpu_data_w-1:0] data,
    output mfrsd_config_u         cfg,
    output mapper_ctrl_u          ctrl,
    output logic [offset_w-1:0]   offset
);

    logic cfg_we;
    logic offset_lo_we;
    logic offset_hi_we;
    logic ctrl_we;

    // Write enables honour the lock bits of the current state
    assign cfg_we       = rom_wr && (addr == reg_config_addr) && !cfg.f.config_lock;
    assign offset_lo_we = rom_wr && (addr == reg_offset_lo_addr) && !ctrl.f.bank_lock;
    assign offset_hi_we = rom_wr && (addr == reg_offset_hi_addr) && !ctrl.f.bank_lock;
    assign ctrl_we      = rom_wr && (addr == reg_mapper_addr) && !ctrl.f.ctrl_lock;

    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            cfg.raw <= config_reset;
        end else if (cfg_we) begin
            cfg.raw <= data;                      // Lock bit can set itself
        end
    end

    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            offset <= '0;
        end else begin
            if (offset_lo_we) begin
                offset[7:0] <= data;              // Low byte of offset
            end
            if (offset_hi_we) begin
                offset[9:8] <= data[1:0];         // Two top bits only
            end
        end
    end

    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            ctrl.raw <= ctrl_reset;               // Konami-SCC, nothing locked
        end else if (ctrl_we) begin
            ctrl.raw <= data;
        end
    end

endmodule

/* common/mfrsd_pkg.sv */
package mfrsd_pkg;

    // Mapper register addresses inside subslot 1
    localparam logic [15:0] reg_config_addr    = 16'h7FFC;
    localparam logic [15:0] reg_offset_lo_addr = 16'h7FFD;
    localparam logic [15:0] reg_offset_hi_addr = 16'h7FFE;
    localparam logic [15:0] reg_mapper_addr    = 16'h7FFF;

    localparam int offset_w = 10;                     // Bank offset width
    localparam int bank_w   = 16;                     // Computed bank number width

    localparam logic [bank_w-1:0] dsk_bank0 = 16'h3FA; // DSK page 0 substitute
    localparam logic [bank_w-1:0] dsk_bank1 = 16'h3FB; // DSK page 1 substitute

    // ROM mapper schemes, the low bit picks a variant
    typedef enum logic [2:0] {
        mode_konami_scc = 3'd0,
        mode_konami     = 3'd1,
        mode_64k_a      = 3'd2,
        mode_64k_b      = 3'd3,
        mode_ascii8_a   = 3'd4,
        mode_ascii8_b   = 3'd5,
        mode_ascii16_a  = 3'd6,
        mode_ascii16_b  = 3'd7
    } rom_mode_e;

    // Configuration register at 7FFC
    typedef struct packed {
        logic config_lock;        // Freezes this register
        logic spare;
        logic mapper_disable;     // Turns off subslot 2
        logic dsk_mode;           // Banks 3FA/3FB on pages 0/1
        logic psg_mirror;
        logic expander_disable;   // Everything goes to subslot 1
        logic block_protect;
        logic flash_we;
    } mfrsd_config_t;

    typedef union packed {
        logic [7:0]    raw;
        mfrsd_config_t f;
    } mfrsd_config_u;

    // Mapper control register at 7FFF
    typedef struct packed {
        rom_mode_e mode;
        logic      spare;
        logic      konami_low_lock;   // Konami writes below 6000 ignored
        logic      ctrl_lock;         // Freezes this register
        logic      bank_lock;         // Freezes banks and offset
        logic      bank_mask;         // Konami bank width limit
    } mapper_ctrl_t;

    typedef union packed {
        logic [7:0]   raw;
        mapper_ctrl_t f;
    } mapper_ctrl_u;

    localparam logic [7:0] config_reset = 8'h02;   // Mapper and expander on, protect set
    localparam logic [7:0] ctrl_reset   = 8'h00;

endpackage

/* common/msx_bus_pkg.sv */
package msx_bus_pkg;

    // CPU side of the MSX cartridge bus
    localparam int cpu_addr_w = 16;   // Z80 address width
    localparam int cpu_data_w = 8;    // Z80 data width

    // Expanded subslot selected by the primary slot decoder
    typedef enum logic [1:0] {
        subslot_0 = 2'd0,             // Fixed RAM window
        subslot_1 = 2'd1,             // ROM mapper
        subslot_2 = 2'd2,             // RAM memory mapper
        subslot_3 = 2'd3              // SD slot, not decoded here
    } subslot_e;

endpackage
